// ==== rtl/rv_decode_defines.svh ====
`ifndef RV_DECODE_DEFINES_SVH
`define RV_DECODE_DEFINES_SVH

// Data and address width for RV32I
`define RV_XLEN 32

// Major opcode field, instr[6:0]
`define RV_OPCODE_W 7

// Immediate select code width
`define RV_IMM_SEL_W 4

// First fetch address out of reset
`define RV_RESET_PC 32'h0000_0000

`endif

// ==== rtl/rv_decode_pkg.sv ====
`default_nettype none

`include "rv_decode_defines.svh"

package rv_decode_pkg;

    // RV32I major opcodes, ISA encodings
    typedef enum logic [`RV_OPCODE_W-1:0] {
        LUI      = 7'b0110111,
        AUIPC    = 7'b0010111,
        JAL      = 7'b1101111,
        // Distinct from JAL in bit 3
        JALR     = 7'b1100111,
        BRANCH   = 7'b1100011,
        LOAD     = 7'b0000011,
        STORE    = 7'b0100011,
        OP_IMM   = 7'b0010011,
        OP       = 7'b0110011,
        // FENCE
        MISC_MEM = 7'b0001111,
        // ECALL and EBREAK
        SYSTEM   = 7'b1110011
    } opcode_e;

    // Immediate format select
    typedef enum logic [`RV_IMM_SEL_W-1:0] {
        IMM_NONE = 4'h0,
        IMM_I    = 4'h1,
        IMM_S    = 4'h2,
        IMM_B    = 4'h3,
        IMM_U    = 4'h4,
        IMM_J    = 4'h5
    } imm_sel_e;

endpackage

`default_nettype wire

// ==== rtl/imm_gen.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "rv_decode_defines.svh"

module imm_gen (
    input  wire logic [`RV_XLEN-1:0]     instr,
    input  rv_decode_pkg::imm_sel_e      imm_sel,
    output logic      [`RV_XLEN-1:0]     imm
);

    // Sign bit of every signed format
    logic sign;

    assign sign = instr[31];

    always_comb begin
        case (imm_sel)
            // Loads, JALR, ALU immediates
            rv_decode_pkg::IMM_I: begin
                imm = {{20{sign}}, instr[31:20]};
            end
            // Stores, offset split around rs2
            rv_decode_pkg::IMM_S: begin
                imm = {{20{sign}}, instr[31:25], instr[11:7]};
            end
            // Branch offset, always even
            rv_decode_pkg::IMM_B: begin
                imm = {{19{sign}}, sign, instr[7], instr[30:25],
                       instr[11:8], 1'b0};
            end
            // LUI and AUIPC, low 12 bits zero
            rv_decode_pkg::IMM_U: begin
                imm = {instr[31:12], 12'h000};
            end
            // JAL offset, 21 bits before extension
            rv_decode_pkg::IMM_J: begin
                imm = {{11{sign}}, sign, instr[19:12], instr[20],
                       instr[30:21], 1'b0};
            end
            default: begin
                // No immediate for this class
                imm = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

// ==== rtl/decode_ctl.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "rv_decode_defines.svh"

module decode_ctl (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic                   stall,
    input  wire logic                   fd_valid,
    input  wire logic [`RV_XLEN-1:0]    fd_pc,
    input  wire logic [`RV_XLEN-1:0]    fd_instr,
    output logic                        valid_exe,
    output logic      [`RV_XLEN-1:0]    pc_exe,
    output logic      [`RV_XLEN-1:0]    instr_exe,
    output rv_decode_pkg::imm_sel_e     imm_sel,
    output logic      [`RV_XLEN-1:0]    imm_exe,
    output logic                        illegal
);

    rv_decode_pkg::opcode_e   opcode;
    rv_decode_pkg::imm_sel_e  imm_sel_d;
    logic                     illegal_d;
    logic [`RV_XLEN-1:0]      imm_d;
    logic                     consume;

    // Instruction taken toward execute this cycle
    assign consume = fd_valid & ~stall;

    assign opcode = rv_decode_pkg::opcode_e'(fd_instr[`RV_OPCODE_W-1:0]);

    // Opcode class to immediate format
    always_comb begin
        imm_sel_d = rv_decode_pkg::IMM_NONE;
        illegal_d = 1'b0;
        case (opcode)
            // Upper immediates
            rv_decode_pkg::LUI,
            rv_decode_pkg::AUIPC: begin
                imm_sel_d = rv_decode_pkg::IMM_U;
            end
            rv_decode_pkg::JAL: begin
                imm_sel_d = rv_decode_pkg::IMM_J;
            end
            // JALR, loads and ALU immediates share the I layout
            rv_decode_pkg::JALR,
            rv_decode_pkg::LOAD,
            rv_decode_pkg::OP_IMM: begin
                imm_sel_d = rv_decode_pkg::IMM_I;
            end
            // SB, SH, SW
            rv_decode_pkg::STORE: begin
                imm_sel_d = rv_decode_pkg::IMM_S;
            end
            // BEQ through BGEU
            rv_decode_pkg::BRANCH: begin
                imm_sel_d = rv_decode_pkg::IMM_B;
            end
            // Register ops, FENCE, ECALL/EBREAK carry no immediate
            rv_decode_pkg::OP,
            rv_decode_pkg::MISC_MEM,
            rv_decode_pkg::SYSTEM: begin
                imm_sel_d = rv_decode_pkg::IMM_NONE;
            end
            default: begin
                // Not an RV32I major opcode
                illegal_d = 1'b1;
            end
        endcase
    end

    imm_gen u_imm_gen (
        .instr   (fd_instr),
        .imm_sel (imm_sel_d),
        .imm     (imm_d)
    );

    // Control side of the execute register
    always_ff @(posedge clk) begin
        if (rst) begin
            valid_exe <= 1'b0;
            imm_sel   <= rv_decode_pkg::IMM_NONE;
            illegal   <= 1'b0;
        end else begin
            // One-cycle strobe per consumed instruction
            valid_exe <= consume;
            if (consume) begin
                imm_sel <= imm_sel_d;
                illegal <= illegal_d;
            end
        end
    end

    // Payload side, loaded with the select
    always_ff @(posedge clk) begin
        if (consume) begin
            pc_exe    <= fd_pc;
            instr_exe <= fd_instr;
            imm_exe   <= imm_d;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/fetch_decode_reg.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "rv_decode_defines.svh"

module fetch_decode_reg (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic                stall,
    input  wire logic                fetch_valid,
    input  wire logic [`RV_XLEN-1:0] fetch_pc,
    input  wire logic [`RV_XLEN-1:0] fetch_instr,
    output logic                     fd_valid,
    output logic      [`RV_XLEN-1:0] fd_pc,
    output logic      [`RV_XLEN-1:0] fd_instr
);

    // Valid bit, bubble when fetch has nothing
    always_ff @(posedge clk) begin
        if (rst) begin
            fd_valid <= 1'b0;
        end else if (!stall) begin
            fd_valid <= fetch_valid;
        end
    end

    // PC and instruction word
    // held as long as stall is up
    always_ff @(posedge clk) begin
        if (!stall) begin
            fd_pc    <= fetch_pc;
            fd_instr <= fetch_instr;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/fetch_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "rv_decode_defines.svh"

module fetch_unit (
    input  wire logic                clk,
    input  wire logic                rst,
    input  wire logic                stall,
    input  wire logic [`RV_XLEN-1:0] imem_rdata,
    output logic      [`RV_XLEN-1:0] imem_addr,
    output logic                     imem_req,
    output logic                     fetch_valid,
    output logic      [`RV_XLEN-1:0] fetch_pc,
    output logic      [`RV_XLEN-1:0] fetch_instr
);

    // Next address to issue
    logic [`RV_XLEN-1:0] pc;
    // Address of the word now in flight
    logic [`RV_XLEN-1:0] issued_pc;
    // Request outstanding, data returns this cycle
    logic                pending;
    // Low for one cycle out of reset
    logic                active;

    // Issue whenever decode is not stalled
    assign imem_req  = active & ~stall;
    assign imem_addr = pc;

    // Memory word arrives one cycle after the request
    assign fetch_valid = pending;
    assign fetch_pc    = issued_pc;
    assign fetch_instr = imem_rdata;

    always_ff @(posedge clk) begin
        if (rst) begin
            pc      <= `RV_RESET_PC;
            pending <= 1'b0;
            active  <= 1'b0;
        end else begin
            active  <= 1'b1;
            pending <= imem_req;
            if (imem_req) begin
                pc <= pc + `RV_XLEN'(4);
            end else if (pending && stall) begin
                // Returning word is dropped by the stalled buffer
                // Point back at it so it is fetched again
                pc <= issued_pc;
            end
        end
    end

    // Issued address, payload only
    always_ff @(posedge clk) begin
        if (imem_req) begin
            issued_pc <= pc;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/rv_decode_top.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "rv_decode_defines.svh"

module rv_decode_top (
    input  wire logic                   clk,
    input  wire logic                   rst,
    input  wire logic                   stall,
    input  wire logic [`RV_XLEN-1:0]    imem_rdata,
    output logic      [`RV_XLEN-1:0]    imem_addr,
    output logic                        imem_req,
    output logic                        valid_exe,
    output logic      [`RV_XLEN-1:0]    pc_exe,
    output logic      [`RV_XLEN-1:0]    instr_exe,
    output rv_decode_pkg::imm_sel_e     imm_sel,
    output logic      [`RV_XLEN-1:0]    imm_exe,
    output logic                        illegal
);

    // Fetch to buffer
    logic                fetch_valid;
    logic [`RV_XLEN-1:0] fetch_pc;
    logic [`RV_XLEN-1:0] fetch_instr;

    // Buffer to decode
    logic                fd_valid;
    logic [`RV_XLEN-1:0] fd_pc;
    logic [`RV_XLEN-1:0] fd_instr;

    // PC and instruction memory port
    fetch_unit u_fetch_unit (
        .clk         (clk),
        .rst         (rst),
        .stall       (stall),
        .imem_rdata  (imem_rdata),
        .imem_addr   (imem_addr),
        .imem_req    (imem_req),
        .fetch_valid (fetch_valid),
        .fetch_pc    (fetch_pc),
        .fetch_instr (fetch_instr)
    );

    // Fetch/decode pipeline register
    fetch_decode_reg u_fetch_decode_reg (
        .clk         (clk),
        .rst         (rst),
        .stall       (stall),
        .fetch_valid (fetch_valid),
        .fetch_pc    (fetch_pc),
        .fetch_instr (fetch_instr),
        .fd_valid    (fd_valid),
        .fd_pc       (fd_pc),
        .fd_instr    (fd_instr)
    );

    // Opcode class, immediate and execute register
    decode_ctl u_decode_ctl (
        .clk       (clk),
        .rst       (rst),
        .stall     (stall),
        .fd_valid  (fd_valid),
        .fd_pc     (fd_pc),
        .fd_instr  (fd_instr),
        .valid_exe (valid_exe),
        .pc_exe    (pc_exe),
        .instr_exe (instr_exe),
        .imm_sel   (imm_sel),
        .imm_exe   (imm_exe),
        .illegal   (illegal)
    );

endmodule

`default_nettype wire

// ==== test/tb_rv_decode_ref.svh ====
`ifndef TB_RV_DECODE_REF_SVH
`define TB_RV_DECODE_REF_SVH

// Galois LFSR step, x^32 + x^22 + x^2 + x + 1
function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    logic [31:0] next;
    next = state >> 1;
    if (state[0]) begin
        next = next ^ 32'h8020_0003;
    end
    return next;
endfunction

// Expected immediate format for a word
function automatic rv_decode_pkg::imm_sel_e ref_imm_sel(input logic [`RV_XLEN-1:0] instr);
    rv_decode_pkg::imm_sel_e sel;
    case (instr[6:0])
        rv_decode_pkg::LUI:    sel = rv_decode_pkg::IMM_U;
        rv_decode_pkg::AUIPC:  sel = rv_decode_pkg::IMM_U;
        rv_decode_pkg::JAL:    sel = rv_decode_pkg::IMM_J;
        // JALR is I type, not J
        rv_decode_pkg::JALR:   sel = rv_decode_pkg::IMM_I;
        rv_decode_pkg::LOAD:   sel = rv_decode_pkg::IMM_I;
        rv_decode_pkg::OP_IMM: sel = rv_decode_pkg::IMM_I;
        rv_decode_pkg::STORE:  sel = rv_decode_pkg::IMM_S;
        rv_decode_pkg::BRANCH: sel = rv_decode_pkg::IMM_B;
        default:               sel = rv_decode_pkg::IMM_NONE;
    endcase
    return sel;
endfunction

// High for anything outside the eleven major opcodes
function automatic logic ref_illegal(input logic [`RV_XLEN-1:0] instr);
    case (instr[6:0])
        rv_decode_pkg::LUI, rv_decode_pkg::AUIPC, rv_decode_pkg::JAL,
        rv_decode_pkg::JALR, rv_decode_pkg::BRANCH, rv_decode_pkg::LOAD,
        rv_decode_pkg::STORE, rv_decode_pkg::OP_IMM, rv_decode_pkg::OP,
        rv_decode_pkg::MISC_MEM, rv_decode_pkg::SYSTEM: return 1'b0;
        default: return 1'b1;
    endcase
endfunction

// Immediate built bit by bit from the ISA layout
function automatic logic [`RV_XLEN-1:0] ref_imm(input logic [`RV_XLEN-1:0] instr,
                                                input rv_decode_pkg::imm_sel_e sel);
    logic [`RV_XLEN-1:0] imm;
    imm = {32{instr[31]}};
    case (sel)
        rv_decode_pkg::IMM_I: begin
            imm = $signed(instr) >>> 20;
        end
        rv_decode_pkg::IMM_S: begin
            imm       = $signed(instr) >>> 20;
            imm[4:0]  = instr[11:7];
        end
        rv_decode_pkg::IMM_B: begin
            imm[11]   = instr[7];
            imm[10:5] = instr[30:25];
            imm[4:1]  = instr[11:8];
            imm[0]    = 1'b0;
        end
        rv_decode_pkg::IMM_U: begin
            imm = instr & 32'hFFFF_F000;
        end
        rv_decode_pkg::IMM_J: begin
            imm[19:12] = instr[19:12];
            imm[11]    = instr[20];
            imm[10:1]  = instr[30:21];
            imm[0]     = 1'b0;
        end
        default: begin
            imm = '0;
        end
    endcase
    return imm;
endfunction

`endif

// ==== test/tb_rv_decode.sv ====
`timescale 1ns/1ns
`default_nettype none

`include "rv_decode_defines.svh"

module tb_rv_decode;

    // One full pass over the memory model per run
    localparam int NUM_WORDS    = 64;
    localparam int REQ_WAIT     = 20;
    localparam int RUN_WAIT     = 1000;
    localparam int PATTERN_LEN  = 1024;
    // Address issue to valid_exe without stall
    localparam int PIPE_LATENCY = 3;

    logic                    clk;
    logic                    rst;
    logic                    stall = 1'b0;
    logic [`RV_XLEN-1:0]     imem_rdata = '0;
    logic [`RV_XLEN-1:0]     imem_addr;
    logic                    imem_req;
    logic                    valid_exe;
    logic [`RV_XLEN-1:0]     pc_exe;
    logic [`RV_XLEN-1:0]     instr_exe;
    rv_decode_pkg::imm_sel_e imm_sel;
    logic [`RV_XLEN-1:0]     imm_exe;
    logic                    illegal;

    logic [`RV_XLEN-1:0] mem [0:NUM_WORDS-1];
    // Precomputed stall level for each cycle
    logic                stall_pattern [0:PATTERN_LEN-1];
    int                  stall_idx = 0;
    logic                stall_on = 1'b0;
    // Back-to-back strobes expected
    logic                gapless = 1'b0;
    logic [31:0]         lfsr_state;

    // Counters of the comparing process
    int                  error_count = 0;
    int                  check_count = 0;
    int                  stall_hits = 0;
    int                  n_seen = 0;
    logic [31:0]         expect_pc = '0;
    logic                last_stall = 1'b0;
    logic                prev_req = 1'b0;
    // Counters of the main sequence
    int                  main_errors = 0;
    int                  main_checks = 0;
    int                  timeout_count = 0;

    `include "tb_rv_decode_ref.svh"

    rv_decode_top UUT (
        .clk        (clk),
        .rst        (rst),
        .stall      (stall),
        .imem_rdata (imem_rdata),
        .imem_addr  (imem_addr),
        .imem_req   (imem_req),
        .valid_exe  (valid_exe),
        .pc_exe     (pc_exe),
        .instr_exe  (instr_exe),
        .imm_sel    (imm_sel),
        .imm_exe    (imm_exe),
        .illegal    (illegal)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    // Memory with one cycle read latency that wraps every 64 words
    always @(posedge clk) begin
        if (imem_req) begin
            imem_rdata <= mem[imem_addr[7:2]];
        end
    end

    always @(posedge clk) begin
        if (stall_on) begin
            stall     <= stall_pattern[stall_idx];
            stall_idx <= (stall_idx + 1) % PATTERN_LEN;
        end else begin
            stall     <= 1'b0;
            stall_idx <= 0;
        end
    end

    // n LFSR steps with one output bit per step
    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            value = {value[30:0], lfsr_state[0]};
        end
        return value;
    endfunction

    // Thirteen opcode classes with the last two unused
    function automatic logic [6:0] class_opcode(input int idx);
        case (idx)
            0:  return rv_decode_pkg::LUI;
            1:  return rv_decode_pkg::AUIPC;
            2:  return rv_decode_pkg::JAL;
            3:  return rv_decode_pkg::JALR;
            4:  return rv_decode_pkg::BRANCH;
            5:  return rv_decode_pkg::LOAD;
            6:  return rv_decode_pkg::STORE;
            7:  return rv_decode_pkg::OP_IMM;
            8:  return rv_decode_pkg::OP;
            9:  return rv_decode_pkg::MISC_MEM;
            10: return rv_decode_pkg::SYSTEM;
            11: return 7'b0001011;
            default: return 7'b1111111;
        endcase
    endfunction

    task automatic fill_stimulus;
        logic [31:0] fields;
        int          run_left;
        run_left = 0;
        // Random upper 25 bits so both signs show up
        for (int i = 0; i < NUM_WORDS; i++) begin
            fields = take_bits(25);
            mem[i] = {fields[24:0], class_opcode(i % 13)};
        end
        // Stall starts one cycle in eight and runs one to four cycles
        for (int c = 0; c < PATTERN_LEN; c++) begin
            if (run_left > 0) begin
                stall_pattern[c] = 1'b1;
                run_left = run_left - 1;
            end else if (take_bits(3) == 32'd0) begin
                stall_pattern[c] = 1'b1;
                run_left = int'(take_bits(2));
            end else begin
                stall_pattern[c] = 1'b0;
            end
        end
    endtask

    task automatic apply_reset;
        rst      <= 1'b1;
        stall_on <= 1'b0;
        gapless  <= 1'b0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
    endtask

    task automatic run_stream(input logic with_stall);
        int cycles;
        apply_reset();
        @(posedge clk);
        // First cycle out of reset
        main_checks++;
        if (valid_exe || illegal || imem_req || imm_sel != rv_decode_pkg::IMM_NONE) begin
            $display("[FAIL] %0t: outputs not idle after reset", $time);
            main_errors++;
        end
        gapless  <= ~with_stall;
        stall_on <= with_stall;
        cycles = 0;
        while (!imem_req && cycles < REQ_WAIT) begin
            @(posedge clk);
            cycles++;
        end
        if (!imem_req) begin
            $display("Timeout: no instruction fetch within %0d cycles of reset", REQ_WAIT);
            timeout_count++;
        end else begin
            main_checks++;
            if (imem_addr != `RV_RESET_PC) begin
                $display("[FAIL] %0t: first fetch address %h", $time, imem_addr);
                main_errors++;
            end
        end
        // First address to first strobe in the free-running pass
        if (!with_stall) begin
            cycles = 0;
            while (!valid_exe && cycles < REQ_WAIT) begin
                @(posedge clk);
                cycles++;
            end
            if (!valid_exe) begin
                $display("Timeout: no valid_exe within %0d cycles of the first fetch",
                         REQ_WAIT);
                timeout_count++;
            end else begin
                main_checks++;
                if (cycles != PIPE_LATENCY) begin
                    $display("[FAIL] %0t: first valid_exe after %0d cycles, expected %0d",
                             $time, cycles, PIPE_LATENCY);
                    main_errors++;
                end
            end
        end
        cycles = 0;
        while (n_seen < NUM_WORDS && cycles < RUN_WAIT) begin
            @(posedge clk);
            cycles++;
        end
        if (n_seen < NUM_WORDS) begin
            $display("Timeout: %0d of %0d instructions decoded in %0d cycles",
                     n_seen, NUM_WORDS, RUN_WAIT);
            timeout_count++;
        end
        stall_on <= 1'b0;
    endtask

    // Compare every execute-side strobe
    always @(posedge clk) begin : compare
        logic [`RV_XLEN-1:0]     word;
        rv_decode_pkg::imm_sel_e exp_sel;
        logic [`RV_XLEN-1:0]     exp_imm;
        logic                    exp_illegal;
        if (rst) begin
            n_seen     <= 0;
            expect_pc  <= `RV_RESET_PC;
            last_stall = 1'b0;
            prev_req   = 1'b0;
        end else begin
            // Stall raised while a word was on its way back
            if (prev_req && stall) begin
                stall_hits++;
            end
            if (valid_exe) begin
                word        = mem[expect_pc[7:2]];
                exp_sel     = ref_imm_sel(word);
                exp_imm     = ref_imm(word, exp_sel);
                exp_illegal = ref_illegal(word);
                check_count++;
                if (pc_exe != expect_pc) begin
                    $display("[FAIL] %0t: pc_exe %h, expected %h", $time, pc_exe, expect_pc);
                    error_count++;
                end
                if (instr_exe != word) begin
                    $display("[FAIL] %0t: instr_exe %h, expected %h", $time, instr_exe, word);
                    error_count++;
                end
                if (imm_sel != exp_sel || illegal != exp_illegal) begin
                    $display("[FAIL] %0t: instr %h imm_sel %0d illegal %b, expected %0d %b",
                             $time, word, imm_sel, illegal, exp_sel, exp_illegal);
                    error_count++;
                end
                if (imm_exe != exp_imm) begin
                    $display("[FAIL] %0t: instr %h imm_exe %h, expected %h",
                             $time, word, imm_exe, exp_imm);
                    error_count++;
                end
                if (last_stall) begin
                    $display("[FAIL] %0t: valid_exe after a stalled cycle", $time);
                    error_count++;
                end
                n_seen    <= n_seen + 1;
                expect_pc <= expect_pc + 32'd4;
            end else if (gapless && n_seen > 0 && n_seen < NUM_WORDS) begin
                // Free-running stream must not have holes
                $display("[FAIL] %0t: gap in valid_exe without stall", $time);
                error_count++;
            end
            last_stall = stall;
            prev_req   = imem_req;
        end
    end

    initial begin
        rst = 1'b1;
        lfsr_state = 32'd79079;
        fill_stimulus();
        // Free-running pass and then the same words under random stall
        run_stream(1'b0);
        run_stream(1'b1);
        if (stall_hits == 0) begin
            $display("Stall never hit a cycle with a returning memory word");
            main_errors++;
        end
        $display("Checks: %0d  Errors: %0d  Timeouts: %0d  Stall hits: %0d",
                 check_count + main_checks, error_count + main_errors,
                 timeout_count, stall_hits);
        if (error_count + main_errors + timeout_count == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== rv_decode.f ====
+incdir+rtl
+incdir+test
rtl/rv_decode_pkg.sv
rtl/imm_gen.sv
rtl/decode_ctl.sv
rtl/fetch_decode_reg.sv
rtl/fetch_unit.sv
rtl/rv_decode_top.sv
test/tb_rv_decode.sv

// ==== Makefile ====
# Verilator simulation of the RV32I decode front end

VERILATOR ?= verilator
TOP       ?= tb_rv_decode
FLAGS     ?= --binary --timing --timescale 1ns/1ns -j 0
FILELIST  := rv_decode.f
OBJ_DIR   := obj_dir

.PHONY: sim clean

# Build, run, and fail unless the pass line shows up
sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- '** PASS **'

clean:
	rm -rf $(OBJ_DIR)
